// ==== hw/dcache_config.svh ====
//////////////////////////////////////////////////
// Cache geometry and bus widths, shared by RTL and testbench
//////////////////////////////////////////////////
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Physical address width in bits
`define PA_BITS 16

// CPU word width
`define XLEN 32

// One cache line, four words
`define DCACHE_BLOCKLENINBITS 128

// Associativity, replacement is built for two
`define DCACHE_NUMWAYS 2

// Bytes per way, gives 16 sets
`define DCACHE_WAYSIZEINBYTES 256

`endif

// ==== hw/dcachePkg.sv ====
//////////////////////////////////////////////////
// Derived cache geometry and the common data types
// Imported by every cache block and by the testbench
//////////////////////////////////////////////////
`include "dcache_config.svh"

package dcachePkg;

  // Raw geometry from the config header
  localparam int blockLen = `DCACHE_BLOCKLENINBITS;
  localparam int numWays = `DCACHE_NUMWAYS;

  // Address split: tag | index | word | byte
  localparam int numLines = `DCACHE_WAYSIZEINBYTES * 8 / blockLen;
  localparam int wordsPerLine = blockLen / `XLEN;
  localparam int offsetLen = $clog2(blockLen / 8);
  localparam int indexLen = $clog2(numLines);
  localparam int tagLen = `PA_BITS - offsetLen - indexLen;
  localparam int logWpl = $clog2(wordsPerLine);
  localparam int logXlenBytes = $clog2(`XLEN / 8);

  typedef logic [blockLen-1:0] lineT;
  typedef logic [`XLEN-1:0] wordT;
  typedef logic [tagLen-1:0] tagT;
  typedef logic [indexLen-1:0] indexT;

  // CPU command on MemRWM, bit 0 write and bit 1 read
  typedef enum logic [1:0] {
    opNone  = 2'b00,
    opWrite = 2'b01,
    opRead  = 2'b10
  } memOpT;

endpackage

// ==== hw/cacheWayIf.sv ====
//////////////////////////////////////////////////
// Shared strobes and write data from the cache datapath to each way
//////////////////////////////////////////////////
`timescale 1ns/1ns

interface cacheWayIf import dcachePkg::*; ();

  // Addressing
  indexT rAdr;
  tagT pAdrTag;
  indexT flushAdr;

  // Array write path
  logic [wordsPerLine-1:0] wordEnable;
  logic blockWrite;
  lineT writeData;

  // Valid and dirty updates
  logic setValid;
  logic clearValid;
  logic setDirty;
  logic clearDirty;

  // Output steering for eviction and flush
  logic selEvict;
  logic selFlush;

  modport ctrl (
    output rAdr, pAdrTag, flushAdr, wordEnable, blockWrite, writeData,
    output setValid, clearValid, setDirty, clearDirty, selEvict, selFlush
  );

  modport way (
    input rAdr, pAdrTag, flushAdr, wordEnable, blockWrite, writeData,
    input setValid, clearValid, setDirty, clearDirty, selEvict, selFlush
  );

endinterface

// ==== hw/cacheRam.sv ====
//////////////////////////////////////////////////
// Synchronous-read array with word write mask
// Holds tags or lines, chosen by the entry type
//////////////////////////////////////////////////
`timescale 1ns/1ns

module cacheRam import dcachePkg::*; #(
  parameter type entryT = lineT,
  parameter int depth = numLines,
  parameter int numWords = 1
) (
  input  logic                clk,
  input  logic                we,
  input  logic [numWords-1:0] wordEnable,
  input  indexT               rAdr,
  input  indexT               wAdr,
  input  entryT               wData,
  output entryT               rData
);

  localparam int wordBits = $bits(entryT) / numWords;

  entryT mem [depth];
  entryT merged;

  // Old entry with the enabled words replaced
  always_comb begin
    merged = mem[wAdr];
    for (int w = 0; w < numWords; w++) begin
      if (wordEnable[w]) begin
        merged[w*wordBits +: wordBits] = wData[w*wordBits +: wordBits];
      end
    end
  end

  // Write-first: a read of the entry being written sees the new value,
  // so a store followed by a load to the same set needs no stall
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wAdr] <= merged;
    end
    if (we && (wAdr == rAdr)) begin
      rData <= merged;
    end else begin
      rData <= mem[rAdr];
    end
  end

endmodule

// ==== hw/cacheWay.sv ====
//////////////////////////////////////////////////
// One cache way: tag and data arrays, valid and dirty flops,
// hit compare and AND-masked outputs for the OR tree in the top
//////////////////////////////////////////////////
`timescale 1ns/1ns

module cacheWay import dcachePkg::*; (
  input  logic         clk,
  input  logic         arstN,
  cacheWayIf.way       bus,
  input  logic         wayWrite,
  input  logic         vdWrite,
  input  logic         victimSel,
  input  logic         flushSel,
  output logic         wayHit,
  output lineT         readLineMasked,
  output tagT          victimTag,
  output logic         victimDirty
);

  indexT rAdrQ;
  indexT vdAdr;
  tagT tagQ;
  lineT lineQ;
  logic [numLines-1:0] validBits;
  logic [numLines-1:0] dirtyBits;
  logic valid;
  logic dirty;
  logic lineSel;
  logic tagSel;

  //////////////////////////////////////////////////
  // Arrays
  //////////////////////////////////////////////////

  // Tag only changes on a line fill
  cacheRam #(
    .entryT(tagT),
    .depth(numLines),
    .numWords(1)
  ) tagRam (
    .clk,
    .we(wayWrite & bus.blockWrite),
    .wordEnable(1'b1),
    .rAdr(bus.rAdr),
    .wAdr(rAdrQ),
    .wData(bus.pAdrTag),
    .rData(tagQ)
  );

  // Word store on hit, whole line on fill
  cacheRam #(
    .entryT(lineT),
    .depth(numLines),
    .numWords(wordsPerLine)
  ) dataRam (
    .clk,
    .we(wayWrite),
    .wordEnable(bus.wordEnable),
    .rAdr(bus.rAdr),
    .wAdr(rAdrQ),
    .wData(bus.writeData),
    .rData(lineQ)
  );

  // Index of the set now on the array outputs, also the write index
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rAdrQ <= '0;
    end else begin
      rAdrQ <= bus.rAdr;
    end
  end

  //////////////////////////////////////////////////
  // Valid and dirty
  //////////////////////////////////////////////////

  // Flush walks the flops by its own counter, no array latency
  assign vdAdr = bus.selFlush ? bus.flushAdr : rAdrQ;
  assign valid = validBits[vdAdr];
  assign dirty = dirtyBits[vdAdr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (wayWrite || vdWrite) begin
      if (bus.setValid) begin
        validBits[vdAdr] <= 1'b1;
      end else if (bus.clearValid) begin
        validBits[vdAdr] <= 1'b0;
      end
      if (bus.setDirty) begin
        dirtyBits[vdAdr] <= 1'b1;
      end else if (bus.clearDirty) begin
        dirtyBits[vdAdr] <= 1'b0;
      end
    end
  end

  // Hit and masked outputs
  assign wayHit = valid && (tagQ == bus.pAdrTag);

  // Line goes out on hit, on eviction of this way, or on its flush turn
  assign lineSel = bus.selFlush ? flushSel : (bus.selEvict ? victimSel : wayHit);
  assign tagSel = bus.selFlush ? flushSel : victimSel;

  assign readLineMasked = lineSel ? lineQ : '0;
  assign victimTag = tagSel ? tagQ : '0;
  assign victimDirty = tagSel && valid && dirty;

endmodule

// ==== hw/lruPolicy.sv ====
//////////////////////////////////////////////////
// Two-way LRU, one bit per set naming the way to replace
//////////////////////////////////////////////////
`timescale 1ns/1ns

module lruPolicy import dcachePkg::*; (
  input  logic               clk,
  input  logic               arstN,
  input  logic [numWays-1:0] wayHit,
  input  logic               fillWrite,
  input  logic               lruWrite,
  input  indexT              index,
  output logic [numWays-1:0] victimWay
);

  // Bit set means way 1 is least recently used
  logic [numLines-1:0] lruBits;
  logic lruSet;

  assign lruSet = lruBits[index];

  // One-hot victim
  assign victimWay = {lruSet, ~lruSet};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lruBits <= '0;
    end else if (lruWrite) begin
      if (fillWrite) begin
        // Filled way becomes most recent, the other one ages
        lruBits[index] <= ~lruSet;
      end else if (|wayHit) begin
        // Hit on way 0 leaves way 1 as the old one
        lruBits[index] <= wayHit[0];
      end
    end
  end

endmodule

// ==== hw/dcacheFsm.sv ====
//////////////////////////////////////////////////
// Cache controller: hit, miss, write-back, fill and flush
// Drives stall and bus levels plus the array strobes
//////////////////////////////////////////////////
`timescale 1ns/1ns

module dcacheFsm import dcachePkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  memOpT      MemRWM,
  input  logic       FlushDCacheM,
  input  logic       DCacheBusAck,
  input  logic       cacheHit,
  input  logic       victimDirty,
  input  logic       flushDone,
  output logic       DCacheStall,
  output logic       DCacheMiss,
  output logic       DCacheAccess,
  output logic       DCacheCommittedM,
  output logic       DCacheFetchLine,
  output logic       DCacheWriteLine,
  output logic [1:0] selAdr,
  output logic       setValid,
  output logic       clearValid,
  output logic       setDirty,
  output logic       clearDirty,
  output logic       wordWrite,
  output logic       blockWrite,
  output logic       selEvict,
  output logic       selFlush,
  output logic       flushAdrCntEn,
  output logic       flushWayCntEn,
  output logic       flushCntRst,
  output logic       vdWrite,
  output logic       lruWrite
);

  // Index sources for the arrays
  localparam logic [1:0] adrNext = 2'd0;
  localparam logic [1:0] adrMiss = 2'd1;
  localparam logic [1:0] adrFlush = 2'd2;

  typedef enum logic [3:0] {
    stReady,
    stWriteBack,
    stFetch,
    stFill,
    stReplay,
    stFlushCheck,
    stFlushWriteBack,
    stFlushAdvance,
    stDone
  } stateT;

  stateT state;
  stateT nextState;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stReady;
    end else begin
      state <= nextState;
    end
  end

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////
  always_comb begin
    nextState = state;
    DCacheStall = 1'b0;
    DCacheMiss = 1'b0;
    DCacheAccess = 1'b0;
    DCacheFetchLine = 1'b0;
    DCacheWriteLine = 1'b0;
    selAdr = adrNext;
    setValid = 1'b0;
    clearValid = 1'b0;
    setDirty = 1'b0;
    clearDirty = 1'b0;
    wordWrite = 1'b0;
    blockWrite = 1'b0;
    selEvict = 1'b0;
    selFlush = 1'b0;
    flushAdrCntEn = 1'b0;
    flushWayCntEn = 1'b0;
    flushCntRst = 1'b0;
    vdWrite = 1'b0;
    lruWrite = 1'b0;

    unique case (state)
      stReady: begin
        // Counters parked at set 0, way 0 between flushes
        flushCntRst = 1'b1;
        if (FlushDCacheM) begin
          DCacheStall = 1'b1;
          selAdr = adrFlush;
          nextState = stFlushCheck;
        end else if (MemRWM != opNone) begin
          DCacheAccess = 1'b1;
          if (cacheHit) begin
            // Zero-cycle hit, store lands at the next edge
            lruWrite = 1'b1;
            if (MemRWM == opWrite) begin
              wordWrite = 1'b1;
              setDirty = 1'b1;
            end
          end else begin
            // Stall now and keep the missing set on the array outputs
            DCacheMiss = 1'b1;
            DCacheStall = 1'b1;
            selAdr = adrMiss;
            nextState = victimDirty ? stWriteBack : stFetch;
          end
        end
      end

      // Victim line and address held until acknowledge
      stWriteBack: begin
        DCacheStall = 1'b1;
        DCacheWriteLine = 1'b1;
        selEvict = 1'b1;
        selAdr = adrMiss;
        if (DCacheBusAck) begin
          nextState = stFetch;
        end
      end

      stFetch: begin
        DCacheStall = 1'b1;
        DCacheFetchLine = 1'b1;
        selAdr = adrMiss;
        if (DCacheBusAck) begin
          // Line and tag written into the victim way, which stays
          // invalid until the fill cycle
          blockWrite = 1'b1;
          clearValid = 1'b1;
          nextState = stFill;
        end
      end

      stFill: begin
        // Victim marked valid and clean, LRU moves to the other way
        DCacheStall = 1'b1;
        selAdr = adrMiss;
        setValid = 1'b1;
        clearDirty = 1'b1;
        vdWrite = 1'b1;
        lruWrite = 1'b1;
        nextState = stReplay;
      end

      stReplay: begin
        // Set reread with the new line, access completes as a hit
        if (MemRWM == opWrite) begin
          wordWrite = 1'b1;
          setDirty = 1'b1;
        end
        nextState = stReady;
      end

      //////////////////////////////////////////////////
      // Flush walk over every set and way
      //////////////////////////////////////////////////
      stFlushCheck: begin
        DCacheStall = 1'b1;
        selFlush = 1'b1;
        selAdr = adrFlush;
        nextState = victimDirty ? stFlushWriteBack : stFlushAdvance;
      end

      stFlushWriteBack: begin
        DCacheStall = 1'b1;
        DCacheWriteLine = 1'b1;
        selFlush = 1'b1;
        selAdr = adrFlush;
        if (DCacheBusAck) begin
          // Line clean again, valid left alone
          clearDirty = 1'b1;
          vdWrite = 1'b1;
          nextState = stFlushAdvance;
        end
      end

      stFlushAdvance: begin
        DCacheStall = 1'b1;
        selFlush = 1'b1;
        selAdr = adrFlush;
        flushWayCntEn = 1'b1;
        flushAdrCntEn = 1'b1;
        nextState = flushDone ? stDone : stFlushCheck;
      end

      // Stall low for one cycle to retire the flush
      stDone: begin
        flushCntRst = 1'b1;
        nextState = stReady;
      end

      default: begin
        nextState = stReady;
      end
    endcase
  end

  // High while the bus sequence for this access is under way
  assign DCacheCommittedM = (state == stWriteBack) || (state == stFetch) ||
                            (state == stFill) || (state == stReplay);

endmodule

// ==== hw/dcache.sv ====
//////////////////////////////////////////////////
// L1 data cache top: ways, LRU, controller and datapath
// CPU request in M stage, line requests to the bus
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache import dcachePkg::*; (
  input  logic                clk,
  input  logic                arstN,
  input  memOpT               MemRWM,
  input  logic                FlushDCacheM,
  input  logic [11:0]         MemAdrE,
  input  logic [`PA_BITS-1:0] LsuPAdrM,
  input  wordT                FinalWriteDataM,
  input  logic                DCacheBusAck,
  input  lineT                DCacheMemWriteData,
  output wordT                ReadDataWordM,
  output logic                DCacheStall,
  output logic                DCacheMiss,
  output logic                DCacheAccess,
  output logic                DCacheCommittedM,
  output logic                DCacheWriteLine,
  output logic                DCacheFetchLine,
  output logic [`PA_BITS-1:0] DCacheBusAdr,
  output lineT                DCacheWriteData
);

  cacheWayIf wayBus ();

  logic [1:0] selAdr;
  logic wordWrite;
  logic vdWrite;
  logic lruWrite;
  logic flushAdrCntEn;
  logic flushWayCntEn;
  logic flushCntRst;
  logic flushDone;
  logic cacheHit;
  logic victimDirty;
  logic [numWays-1:0] wayHit;
  logic [numWays-1:0] victimWay;
  logic [numWays-1:0] flushWay;
  logic [numWays-1:0] wayWrite;
  logic [numWays-1:0] vdWriteWay;
  logic [numWays-1:0] victimDirtyWay;
  lineT readLineWay [numWays];
  tagT victimTagWay [numWays];
  lineT readLine;
  tagT victimTag;
  indexT pAdrIndex;
  indexT flushAdr;
  logic [logWpl-1:0] wordSel;
  logic [wordsPerLine-1:0] wordDecoded;

  //////////////////////////////////////////////////
  // Index and write path
  //////////////////////////////////////////////////
  assign pAdrIndex = LsuPAdrM[offsetLen +: indexLen];
  assign wordSel = LsuPAdrM[logXlenBytes +: logWpl];

  // Next request from E stage, missing set, or flush walk
  always_comb begin
    unique case (selAdr)
      2'd0:    wayBus.rAdr = MemAdrE[offsetLen +: indexLen];
      2'd1:    wayBus.rAdr = pAdrIndex;
      default: wayBus.rAdr = flushAdr;
    endcase
  end

  assign wayBus.pAdrTag = LsuPAdrM[`PA_BITS-1 -: tagLen];
  assign wayBus.flushAdr = flushAdr;

  // Store word copied into every slot, the mask picks one
  assign wordDecoded = {{(wordsPerLine-1){1'b0}}, 1'b1} << wordSel;
  assign wayBus.wordEnable = wayBus.blockWrite ? '1 : wordDecoded;
  assign wayBus.writeData = wayBus.blockWrite ? DCacheMemWriteData
                                              : {wordsPerLine{FinalWriteDataM}};

  // Fill goes to the victim, a store to the hitting way
  assign wayWrite = wayBus.blockWrite ? victimWay : (wordWrite ? wayHit : '0);
  assign vdWriteWay = {numWays{vdWrite}} & (wayBus.selFlush ? flushWay : victimWay);

  //////////////////////////////////////////////////
  // Ways and replacement
  //////////////////////////////////////////////////
  for (genvar w = 0; w < numWays; w++) begin : gWay
    cacheWay wayI (
      .clk,
      .arstN,
      .bus(wayBus),
      .wayWrite(wayWrite[w]),
      .vdWrite(vdWriteWay[w]),
      .victimSel(victimWay[w]),
      .flushSel(flushWay[w]),
      .wayHit(wayHit[w]),
      .readLineMasked(readLineWay[w]),
      .victimTag(victimTagWay[w]),
      .victimDirty(victimDirtyWay[w])
    );
  end

  // Fill is the only cycle that sets valid
  lruPolicy lruI (
    .clk,
    .arstN,
    .wayHit,
    .fillWrite(wayBus.setValid),
    .lruWrite,
    .index(pAdrIndex),
    .victimWay
  );

  // OR half of the AND-OR mux, ways already masked
  always_comb begin
    readLine = '0;
    victimTag = '0;
    for (int w = 0; w < numWays; w++) begin
      readLine = readLine | readLineWay[w];
      victimTag = victimTag | victimTagWay[w];
    end
  end

  assign cacheHit = |wayHit;
  assign victimDirty = |victimDirtyWay;
  assign ReadDataWordM = readLine[wordSel*`XLEN +: `XLEN];
  assign DCacheWriteData = readLine;

  // Line-aligned bus address
  always_comb begin
    if (wayBus.selFlush) begin
      DCacheBusAdr = {victimTag, flushAdr, {offsetLen{1'b0}}};
    end else if (wayBus.selEvict) begin
      DCacheBusAdr = {victimTag, pAdrIndex, {offsetLen{1'b0}}};
    end else begin
      DCacheBusAdr = {LsuPAdrM[`PA_BITS-1:offsetLen], {offsetLen{1'b0}}};
    end
  end

  //////////////////////////////////////////////////
  // Flush counters
  //////////////////////////////////////////////////

  // Way rotates every step, set moves on after the last way
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flushAdr <= '0;
      flushWay <= {{(numWays-1){1'b0}}, 1'b1};
    end else if (flushCntRst) begin
      flushAdr <= '0;
      flushWay <= {{(numWays-1){1'b0}}, 1'b1};
    end else begin
      if (flushAdrCntEn && flushWay[numWays-1]) begin
        flushAdr <= flushAdr + 1'b1;
      end
      if (flushWayCntEn) begin
        flushWay <= {flushWay[numWays-2:0], flushWay[numWays-1]};
      end
    end
  end

  assign flushDone = (flushAdr == indexT'(numLines - 1)) && flushWay[numWays-1];

  // Controller
  dcacheFsm fsmI (
    .clk,
    .arstN,
    .MemRWM,
    .FlushDCacheM,
    .DCacheBusAck,
    .cacheHit,
    .victimDirty,
    .flushDone,
    .DCacheStall,
    .DCacheMiss,
    .DCacheAccess,
    .DCacheCommittedM,
    .DCacheFetchLine,
    .DCacheWriteLine,
    .selAdr,
    .setValid(wayBus.setValid),
    .clearValid(wayBus.clearValid),
    .setDirty(wayBus.setDirty),
    .clearDirty(wayBus.clearDirty),
    .wordWrite,
    .blockWrite(wayBus.blockWrite),
    .selEvict(wayBus.selEvict),
    .selFlush(wayBus.selFlush),
    .flushAdrCntEn,
    .flushWayCntEn,
    .flushCntRst,
    .vdWrite,
    .lruWrite
  );

endmodule

// ==== tests/busMemory.sv ====
//////////////////////////////////////////////////
// Backing memory for the cache testbench
// Answers line fetches and write-backs, counts transfers
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "dcache_config.svh"

module busMemory import dcachePkg::*; #(
  parameter logic [31:0] fillSeed = 32'h1
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                fetchLine,
  input  logic                writeLine,
  input  logic [`PA_BITS-1:0] busAdr,
  input  lineT                writeData,
  output logic                ack,
  output lineT                readData,
  output int                  fetchCount,
  output int                  writeCount,
  output logic [`PA_BITS-1:0] lastFetchAdr,
  output logic [`PA_BITS-1:0] lastWriteAdr
);

  // Ack comes three cycles after the request rises
  localparam int ackDelay = 3;
  localparam int memWords = 2 ** (`PA_BITS - 2);

  wordT mem [memWords];
  int waitCnt;
  logic [`PA_BITS-3:0] lineBase;

  // Word index of word 0 in the addressed line
  assign lineBase = {busAdr[`PA_BITS-1:offsetLen], {logWpl{1'b0}}};

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ack <= 1'b0;
      readData <= '0;
      waitCnt <= 0;
      fetchCount <= 0;
      writeCount <= 0;
      lastFetchAdr <= '0;
      lastWriteAdr <= '0;
      // Image seeded per word index
      for (int i = 0; i < memWords; i++) begin
        mem[i] <= xorshift(fillSeed + i);
      end
    end else if (ack) begin
      // Requester drops or swaps its level at this edge
      ack <= 1'b0;
      waitCnt <= 0;
    end else if (fetchLine || writeLine) begin
      if (waitCnt == ackDelay - 1) begin
        ack <= 1'b1;
        waitCnt <= 0;
        if (fetchLine) begin
          for (int w = 0; w < wordsPerLine; w++) begin
            readData[w*`XLEN +: `XLEN] <= mem[lineBase + w];
          end
          fetchCount <= fetchCount + 1;
          lastFetchAdr <= busAdr;
        end else begin
          for (int w = 0; w < wordsPerLine; w++) begin
            mem[lineBase + w] <= writeData[w*`XLEN +: `XLEN];
          end
          writeCount <= writeCount + 1;
          lastWriteAdr <= busAdr;
        end
      end else begin
        waitCnt <= waitCnt + 1;
      end
    end
  end

endmodule

// ==== tests/dcacheTb.sv ====
//////////////////////////////////////////////////
// Directed tests for the L1 data cache against a reference memory
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcacheTb import dcachePkg::*; ();

  localparam int clkPeriod = 100;
  localparam int waitLimit = 200;
  localparam logic [31:0] seed = 32'he864f91b;
  localparam int memWords = 2 ** (`PA_BITS - 2);

  logic clk;
  logic arstN;
  memOpT MemRWM;
  logic FlushDCacheM;
  logic [11:0] MemAdrE;
  logic [`PA_BITS-1:0] LsuPAdrM;
  wordT FinalWriteDataM;
  logic DCacheBusAck;
  lineT DCacheMemWriteData;
  wordT ReadDataWordM;
  logic DCacheStall;
  logic DCacheMiss;
  logic DCacheAccess;
  logic DCacheCommittedM;
  logic DCacheWriteLine;
  logic DCacheFetchLine;
  logic [`PA_BITS-1:0] DCacheBusAdr;
  lineT DCacheWriteData;
  int fetchCount;
  int writeCount;
  logic [`PA_BITS-1:0] lastFetchAdr;
  logic [`PA_BITS-1:0] lastWriteAdr;

  // Reference model and bookkeeping
  wordT refMem [memWords];
  logic [31:0] rngState;
  int errors;
  int testErrors;
  int testsRun;
  int testsFailed;
  int stallCycles;
  int accessPulses;
  int missPulses;
  wordT readWord;

  dcache dcache_i (
    .clk, .arstN, .MemRWM, .FlushDCacheM, .MemAdrE, .LsuPAdrM, .FinalWriteDataM,
    .DCacheBusAck, .DCacheMemWriteData, .ReadDataWordM, .DCacheStall, .DCacheMiss,
    .DCacheAccess, .DCacheCommittedM, .DCacheWriteLine, .DCacheFetchLine,
    .DCacheBusAdr, .DCacheWriteData
  );

  busMemory #(.fillSeed(seed)) busMemI (
    .clk,
    .arstN,
    .fetchLine(DCacheFetchLine),
    .writeLine(DCacheWriteLine),
    .busAdr(DCacheBusAdr),
    .writeData(DCacheWriteData),
    .ack(DCacheBusAck),
    .readData(DCacheMemWriteData),
    .fetchCount,
    .writeCount,
    .lastFetchAdr,
    .lastWriteAdr
  );

  always #(clkPeriod / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      testErrors++;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic abortOnTimeout(input string why);
    errors++;
    $display("Timeout after %0d cycles: %s", waitLimit, why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (testErrors == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, testErrors);
      testsFailed++;
    end
    errors += testErrors;
    testErrors = 0;
  endtask

  // Pulses counted per access, commit must cover every bus request
  task automatic sampleStrobes();
    accessPulses += DCacheAccess;
    missPulses += DCacheMiss;
    if (DCacheFetchLine || DCacheWriteLine) begin
      checkValue("DCacheCommittedM", DCacheCommittedM, 1);
    end
  endtask

  // Index one cycle early on MemAdrE and then the request until stall drops
  task automatic access(input memOpT op, input logic [`PA_BITS-1:0] adr, input wordT data);
    @(posedge clk);
    #1;
    MemRWM = opNone;
    MemAdrE = adr[11:0];
    @(posedge clk);
    #1;
    MemRWM = op;
    LsuPAdrM = adr;
    FinalWriteDataM = data;
    stallCycles = 0;
    accessPulses = 0;
    missPulses = 0;
    @(negedge clk);
    sampleStrobes();
    while (DCacheStall && stallCycles < waitLimit) begin
      stallCycles++;
      @(negedge clk);
      sampleStrobes();
    end
    if (DCacheStall) begin
      abortOnTimeout("DCacheStall stayed high during a CPU access");
    end else begin
      readWord = ReadDataWordM;
      @(posedge clk);
      #1;
      MemRWM = opNone;
    end
  endtask

  task automatic writeWord(input logic [`PA_BITS-1:0] adr, input wordT data);
    access(opWrite, adr, data);
    refMem[adr[`PA_BITS-1:2]] = data;
  endtask

  task automatic readCheck(input logic [`PA_BITS-1:0] adr);
    access(opRead, adr, '0);
    checkValue("ReadDataWordM", readWord, refMem[adr[`PA_BITS-1:2]]);
  endtask

  // Flush held high until the walk retires
  task automatic flushCache();
    int cycles;
    @(posedge clk);
    #1;
    FlushDCacheM = 1'b1;
    cycles = 0;
    @(negedge clk);
    while (DCacheStall && cycles < waitLimit) begin
      cycles++;
      @(negedge clk);
    end
    if (DCacheStall) begin
      abortOnTimeout("DCacheStall stayed high during a flush");
    end else begin
      @(posedge clk);
      #1;
      FlushDCacheM = 1'b0;
    end
  endtask

  task automatic compareMemory();
    int mismatches;
    mismatches = 0;
    for (int i = 0; i < memWords; i++) begin
      if (busMemI.mem[i] !== refMem[i]) begin
        mismatches++;
        if (mismatches <= 4) begin
          $display("** Error at %0t ns: busMemI.mem[%0h] = %h, expected %h",
                   $time, i, busMemI.mem[i], refMem[i]);
        end
      end
    end
    testErrors += mismatches;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic readMissTest();
    int fetchBefore;
    int writeBefore;
    fetchBefore = fetchCount;
    writeBefore = writeCount;
    // Idle outputs after reset
    checkValue("DCacheStall", DCacheStall, 0);
    checkValue("DCacheFetchLine", DCacheFetchLine, 0);
    checkValue("DCacheWriteLine", DCacheWriteLine, 0);
    checkValue("DCacheCommittedM", DCacheCommittedM, 0);
    checkValue("DCacheMiss", DCacheMiss, 0);
    checkValue("DCacheAccess", DCacheAccess, 0);
    readCheck(16'h0124);
    checkValue("DCacheAccess pulses", accessPulses, 1);
    checkValue("DCacheMiss pulses", missPulses, 1);
    checkValue("fetchCount", fetchCount - fetchBefore, 1);
    checkValue("writeCount", writeCount - writeBefore, 0);
    checkValue("lastFetchAdr", lastFetchAdr, 16'h0120);
    endTest("read miss");
  endtask

  task automatic readHitTest();
    int fetchBefore;
    fetchBefore = fetchCount;
    readCheck(16'h0124);
    checkValue("stall cycles", stallCycles, 0);
    checkValue("DCacheAccess pulses", accessPulses, 1);
    checkValue("DCacheMiss pulses", missPulses, 0);
    readCheck(16'h012C);
    checkValue("stall cycles", stallCycles, 0);
    checkValue("fetchCount", fetchCount - fetchBefore, 0);
    endTest("read hit");
  endtask

  task automatic writeReadTest();
    int busBefore;
    busBefore = fetchCount + writeCount;
    writeWord(16'h0128, nextRandom());
    checkValue("stall cycles", stallCycles, 0);
    readCheck(16'h0128);
    // Neighbours in the line keep their data
    readCheck(16'h0120);
    readCheck(16'h0124);
    readCheck(16'h012C);
    checkValue("bus transfers", fetchCount + writeCount - busBefore, 0);
    endTest("write then read");
  endtask

  task automatic dirtyEvictTest();
    int fetchBefore;
    int writeBefore;
    fetchBefore = fetchCount;
    writeBefore = writeCount;
    // Tags 10, 20 and 30 share set 5
    writeWord(16'h1050, nextRandom());
    writeWord(16'h2054, nextRandom());
    checkValue("writeCount", writeCount - writeBefore, 0);
    readCheck(16'h3058);
    checkValue("DCacheMiss pulses", missPulses, 1);
    checkValue("writeCount", writeCount - writeBefore, 1);
    checkValue("lastWriteAdr", lastWriteAdr, 16'h1050);
    checkValue("fetchCount", fetchCount - fetchBefore, 3);
    checkValue("lastFetchAdr", lastFetchAdr, 16'h3050);
    for (int w = 0; w < wordsPerLine; w++) begin
      checkValue("busMemI.mem", busMemI.mem[(16'h1050 >> 2) + w], refMem[(16'h1050 >> 2) + w]);
    end
    endTest("dirty eviction");
  endtask

  task automatic flushTest();
    int writeBefore;
    writeWord(16'h0540, nextRandom());
    writeWord(16'h0944, nextRandom());
    writeWord(16'h0A78, nextRandom());
    // Dirty lines are 0120, 2050 and the three above
    writeBefore = writeCount;
    flushCache();
    checkValue("flush write-backs", writeCount - writeBefore, 5);
    compareMemory();
    writeBefore = writeCount;
    flushCache();
    checkValue("second flush write-backs", writeCount - writeBefore, 0);
    endTest("flush");
  endtask

  task automatic randomTest();
    logic [31:0] r;
    logic [`PA_BITS-1:0] adr;
    for (int n = 0; n < 200; n++) begin
      r = nextRandom();
      // 64 lines from 4000 with four tags per set
      adr = {6'b010000, r[5:0], r[7:6], 2'b00};
      if (r[8]) begin
        writeWord(adr, nextRandom());
      end else begin
        readCheck(adr);
      end
    end
    flushCache();
    compareMemory();
    endTest("random sequence");
  endtask

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    MemRWM = opNone;
    FlushDCacheM = 1'b0;
    MemAdrE = '0;
    LsuPAdrM = '0;
    FinalWriteDataM = '0;
    rngState = seed;
    errors = 0;
    testErrors = 0;
    testsRun = 0;
    testsFailed = 0;
    stallCycles = 0;
    accessPulses = 0;
    missPulses = 0;
    readWord = '0;
    repeat (4) @(posedge clk);
    #1;
    arstN = 1'b1;
    // Reference starts from the bus memory image
    for (int i = 0; i < memWords; i++) begin
      refMem[i] = busMemI.mem[i];
    end

    readMissTest();
    readHitTest();
    writeReadTest();
    dirtyEvictTest();
    flushTest();
    randomTest();

    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/dcachePkg.sv
hw/cacheWayIf.sv
hw/cacheRam.sv
hw/cacheWay.sv
hw/lruPolicy.sv
hw/dcacheFsm.sv
hw/dcache.sv
tests/busMemory.sv
tests/dcacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the data cache testbench with Verilator and run it.
# The run fails when the log holds the failure message.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 \
  -f files.f \
  --top-module dcacheTb \
  -o dcacheSim

./obj_dir/dcacheSim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi

echo "Run finished without failures"
exit 0
